// File: verilog/riscv_isa_pkg.sv
package riscv_isa_pkg;

    localparam int xlen = 32;       // data and address width
    localparam int reg_addr_w = 5;  // register index width

    typedef enum logic [6:0] {
        op_rtype   = 7'b0110011,
        op_itypel  = 7'b0000011,  // loads
        op_ityper  = 7'b0010011,  // alu immediate
        op_itypeiw = 7'b0011011,
        op_stype   = 7'b0100011,
        op_utype   = 7'b0110111,  // lui
        op_rtypew  = 7'b0111011,
        op_sbtype  = 7'b1100011,
        op_itypej  = 7'b1100111,  // jalr
        op_jtype   = 7'b1101111,  // jal
        op_auipc   = 7'b0010111
    } opcode_t;

    // code is {bit30, funct3}
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sub = 4'b1000,
        alu_sll = 4'b0001,
        alu_slt = 4'b0010,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_sra = 4'b1101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_lui = 4'b0011,
        alu_nop = 4'b1111
    } aluop_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        opcode_t               opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_t               opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    localparam logic [1:0] dw_byte = 2'b00;
    localparam logic [1:0] dw_half = 2'b01;
    localparam logic [1:0] dw_word = 2'b10;

    localparam logic [1:0] jmp_none = 2'b00;
    localparam logic [1:0] jmp_jal  = 2'b01;
    localparam logic [1:0] jmp_jalr = 2'b10;

    localparam logic [2:0] br_none = 3'b000;
    localparam logic [2:0] br_eq   = 3'b100;
    localparam logic [2:0] br_ne   = 3'b101;
    localparam logic [2:0] br_lt   = 3'b110;
    localparam logic [2:0] br_ge   = 3'b111;

    typedef struct packed {
        logic [1:0]            datawidth;
        logic [1:0]            jump;
        logic [2:0]            branch;
        logic                  memread;
        logic                  mem_to_reg;
        riscv_isa_pkg::aluop_t aluop;
        logic                  mem_write;
        logic                  alusrc;
        logic                  regwrite;
        logic                  auipc;
    } ctrl_t;

    typedef struct packed {
        logic                             valid;
        logic [31:0]                      instr;
        logic [riscv_isa_pkg::xlen-1:0]   pc;
        logic [riscv_isa_pkg::xlen-1:0]   rs1_val;
        logic [riscv_isa_pkg::xlen-1:0]   rs2_val;
    } issue_t;

    typedef struct packed {
        logic                                 valid;
        ctrl_t                                ctrl;
        logic [riscv_isa_pkg::reg_addr_w-1:0] rd;
        logic [riscv_isa_pkg::xlen-1:0]       pc;
        logic [riscv_isa_pkg::xlen-1:0]       rs1_val;
        logic [riscv_isa_pkg::xlen-1:0]       rs2_val;
        logic [riscv_isa_pkg::xlen-1:0]       imm;
    } dec_t;

    typedef struct packed {
        logic                                 valid;
        ctrl_t                                ctrl;
        logic [riscv_isa_pkg::reg_addr_w-1:0] rd;
        logic [riscv_isa_pkg::xlen-1:0]       pc;
        logic [riscv_isa_pkg::xlen-1:0]       alu_res;
        logic [riscv_isa_pkg::xlen-1:0]       store_data;
        logic [riscv_isa_pkg::xlen-1:0]       imm;
        logic [riscv_isa_pkg::xlen-1:0]       rs1_val;
        logic                                 taken;
    } ex_t;

    typedef struct packed {
        logic                                 valid;
        logic [riscv_isa_pkg::reg_addr_w-1:0] rd;
        logic                                 rd_write;
        logic [riscv_isa_pkg::xlen-1:0]       rd_value;
        logic                                 mem_read;
        logic                                 mem_write;
        logic [1:0]                           mem_width;
        logic [riscv_isa_pkg::xlen-1:0]       mem_addr;
        logic [riscv_isa_pkg::xlen-1:0]       store_data;
        logic                                 redirect;
        logic [riscv_isa_pkg::xlen-1:0]       next_pc;
    } result_t;

endpackage

// File: verilog/control_unit.sv
`timescale 1ns/1ns

module control_unit (
    input  riscv_isa_pkg::opcode_t opcode,
    input  logic [2:0]             funct3,
    input  logic                   bit30,
    output pipe_pkg::ctrl_t        ctrl
);
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    always_comb begin
        // idle defaults, overridden per opcode below
        ctrl.datawidth  = dw_byte;
        ctrl.jump       = jmp_none;
        ctrl.branch     = br_none;
        ctrl.memread    = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.aluop      = alu_nop;
        ctrl.mem_write  = 1'b0;
        ctrl.alusrc     = 1'b0;
        ctrl.regwrite   = 1'b0;
        ctrl.auipc      = 1'b0;

        case (opcode)
            op_rtype, op_rtypew: begin
                ctrl.regwrite = 1'b1;
                if (funct3 == 3'b011) begin
                    ctrl.aluop = alu_nop;  // sltu not supported
                end else begin
                    ctrl.aluop = aluop_t'({bit30, funct3});
                end
            end
            op_itypel: begin
                ctrl.memread    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.aluop      = alu_add;
                ctrl.alusrc     = 1'b1;
                ctrl.regwrite   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.datawidth = dw_byte;
                    3'b001:  ctrl.datawidth = dw_half;
                    default: ctrl.datawidth = dw_word;
                endcase
            end
            op_ityper, op_itypeiw: begin
                ctrl.alusrc   = 1'b1;
                ctrl.regwrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluop = alu_add;
                    3'b001:  ctrl.aluop = alu_sll;
                    3'b010:  ctrl.aluop = (opcode == op_ityper) ? alu_slt : alu_nop;
                    3'b100:  ctrl.aluop = (opcode == op_ityper) ? alu_xor : alu_nop;
                    3'b101:  ctrl.aluop = bit30 ? alu_sra : alu_srl;
                    3'b110:  ctrl.aluop = (opcode == op_ityper) ? alu_or : alu_nop;
                    3'b111:  ctrl.aluop = (opcode == op_ityper) ? alu_and : alu_nop;
                    default: ctrl.aluop = alu_nop;  // sltiu
                endcase
            end
            op_stype: begin
                ctrl.mem_write = 1'b1;
                ctrl.aluop     = alu_add;
                ctrl.alusrc    = 1'b1;
                case (funct3)
                    3'b000:  ctrl.datawidth = dw_byte;
                    3'b001:  ctrl.datawidth = dw_half;
                    default: ctrl.datawidth = dw_word;
                endcase
            end
            op_utype: begin
                ctrl.alusrc   = 1'b1;
                ctrl.aluop    = alu_lui;
                ctrl.regwrite = 1'b1;
            end
            op_sbtype: begin
                ctrl.aluop = alu_sub;
                case (funct3)
                    3'b000:  ctrl.branch = br_eq;
                    3'b001:  ctrl.branch = br_ne;
                    3'b100:  ctrl.branch = br_lt;
                    3'b101:  ctrl.branch = br_ge;
                    default: ctrl.branch = br_none;  // unsigned compares dropped
                endcase
            end
            op_itypej: begin
                ctrl.jump     = jmp_jalr;
                ctrl.alusrc   = 1'b1;
                ctrl.aluop    = alu_add;
                ctrl.regwrite = 1'b1;
            end
            op_jtype: begin
                ctrl.jump     = jmp_jal;
                ctrl.regwrite = 1'b1;
            end
            op_auipc: begin
                ctrl.alusrc   = 1'b1;
                ctrl.aluop    = alu_add;
                ctrl.regwrite = 1'b1;
                ctrl.auipc    = 1'b1;
            end
            default: begin
                ctrl.aluop = alu_nop;
            end
        endcase
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  pipe_pkg::issue_t issue,
    output pipe_pkg::dec_t   dec
);
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    instr_u           iw;
    ctrl_t            ctrl;
    logic [xlen-1:0]  imm;
    logic             is_shift;

    assign iw = issue.instr;

    control_unit u_ctrl (
        .opcode (iw.r.opcode),
        .funct3 (iw.r.funct3),
        .bit30  (iw.r.funct7[5]),
        .ctrl   (ctrl)
    );

    assign is_shift = (iw.i.funct3 == 3'b001) || (iw.i.funct3 == 3'b101);

    always_comb begin
        case (iw.r.opcode)
            op_itypel, op_itypej: imm = {{(xlen-12){iw.i.imm[11]}}, iw.i.imm};
            op_ityper, op_itypeiw: begin
                if (is_shift) begin
                    imm = {{(xlen-5){1'b0}}, iw.i.imm[4:0]};  // shamt only
                end else begin
                    imm = {{(xlen-12){iw.i.imm[11]}}, iw.i.imm};
                end
            end
            op_stype: imm = {{(xlen-12){iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
            op_sbtype: imm = {{(xlen-12){iw.b.imm_12}}, iw.b.imm_11, iw.b.imm_10_5,
                              iw.b.imm_4_1, 1'b0};
            op_utype, op_auipc: imm = {iw.u.imm_31_12, 12'b0};
            op_jtype: imm = {{(xlen-20){iw.j.imm_20}}, iw.j.imm_19_12, iw.j.imm_11,
                             iw.j.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        dec.valid   <= issue.valid;
        dec.ctrl    <= ctrl;
        dec.rd      <= iw.r.rd;
        dec.pc      <= issue.pc;
        dec.rs1_val <= issue.rs1_val;
        dec.rs2_val <= issue.rs2_val;
        dec.imm     <= imm;
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end
    end

    a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        dec.valid |-> !$isunknown(dec.ctrl));

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  pipe_pkg::dec_t dec,
    output pipe_pkg::ex_t  ex
);
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;
    logic [4:0]      shamt;
    logic            taken;

    assign op_a  = dec.ctrl.auipc ? dec.pc : dec.rs1_val;
    assign op_b  = dec.ctrl.alusrc ? dec.imm : dec.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.ctrl.aluop)
            alu_add: alu_res = op_a + op_b;
            alu_sub: alu_res = op_a - op_b;
            alu_sll: alu_res = op_a << shamt;
            alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_xor: alu_res = op_a ^ op_b;
            alu_srl: alu_res = op_a >> shamt;
            alu_sra: alu_res = $unsigned($signed(op_a) >>> shamt);
            alu_or:  alu_res = op_a | op_b;
            alu_and: alu_res = op_a & op_b;
            alu_lui: alu_res = op_b;
            default: alu_res = '0;  // nop and unused codes
        endcase
    end

    // compares the raw register operands, not the alu inputs
    always_comb begin
        case (dec.ctrl.branch)
            br_eq:   taken = (dec.rs1_val == dec.rs2_val);
            br_ne:   taken = (dec.rs1_val != dec.rs2_val);
            br_lt:   taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
            br_ge:   taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        ex.valid      <= dec.valid;
        ex.ctrl       <= dec.ctrl;
        ex.rd         <= dec.rd;
        ex.pc         <= dec.pc;
        ex.alu_res    <= alu_res;
        ex.store_data <= dec.rs2_val;
        ex.imm        <= dec.imm;
        ex.rs1_val    <= dec.rs1_val;
        ex.taken      <= taken;
        if (!rst_n) begin
            ex.valid <= 1'b0;
        end
    end

    a_jump_xor_branch: assert property (@(posedge clk) disable iff (!rst_n)
        dec.valid |-> !((dec.ctrl.jump != jmp_none) && (dec.ctrl.branch != br_none)));

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/1ns

module result_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::ex_t     ex,
    output pipe_pkg::result_t result
);
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] jalr_target;
    logic [xlen-1:0] next_pc;
    logic            is_jump;

    assign pc_plus4    = ex.pc + 32'd4;
    assign pc_target   = ex.pc + ex.imm;
    assign jalr_target = (ex.rs1_val + ex.imm) & ~32'd1;
    assign is_jump     = (ex.ctrl.jump != jmp_none);

    always_comb begin
        if (ex.ctrl.jump == jmp_jalr) begin
            next_pc = jalr_target;
        end else if (ex.ctrl.jump == jmp_jal || ex.taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        result.valid      <= ex.valid;
        result.rd         <= ex.rd;
        result.rd_write   <= ex.valid && ex.ctrl.regwrite && (ex.rd != '0);
        result.rd_value   <= is_jump ? pc_plus4 : ex.alu_res;  // link address
        result.mem_read   <= ex.valid && ex.ctrl.memread;
        result.mem_write  <= ex.valid && ex.ctrl.mem_write;
        result.mem_width  <= ex.ctrl.datawidth;
        result.mem_addr   <= ex.alu_res;
        result.store_data <= ex.store_data;
        result.redirect   <= ex.valid && (is_jump || ex.taken);
        result.next_pc    <= next_pc;
        if (!rst_n) begin
            result.valid     <= 1'b0;
            result.rd_write  <= 1'b0;
            result.mem_read  <= 1'b0;
            result.mem_write <= 1'b0;
            result.redirect  <= 1'b0;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid |-> !result.next_pc[0]);

endmodule

// File: verilog/exec_core.sv
`timescale 1ns/1ns

module exec_core (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::issue_t  issue,
    output pipe_pkg::result_t result
);
    import pipe_pkg::*;

    dec_t dec_w;  // decode to execute
    ex_t  ex_w;   // execute to result

    decode_stage u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .dec   (dec_w)
    );

    execute_stage u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec_w),
        .ex    (ex_w)
    );

    result_stage u_result (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex     (ex_w),
        .result (result)
    );

endmodule

// File: bench/tb_exec_core.sv
`timescale 1ns/1ns

module tb_exec_core;
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int reset_cycles = 2;
    localparam int latency      = 3;   // issue edge counts as the first register
    localparam int n_directed   = 60;  // directed issues plus idle gaps rounded up
    localparam int n_rand       = 300;
    localparam int max_cycles   = reset_cycles + n_directed + n_rand + latency + 35;

    logic        clk;
    logic        rst_n;
    issue_t      issue;
    result_t     result;

    result_t     exp_q[$];
    int          due_q[$];
    result_t     exp_r;
    int          due;
    int          cycle     = 0;
    int          err_cnt   = 0;
    int          other_cnt = 0;
    int          check_cnt = 0;
    logic [31:0] rng;
    logic [31:0] cur_pc;

    opcode_t legal_ops [11] = '{op_rtype, op_itypel, op_ityper, op_itypeiw, op_stype,
        op_utype, op_rtypew, op_sbtype, op_itypej, op_jtype, op_auipc};

    exec_core dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue),
        .result (result)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng = xorshift32(rng);
        v = rng;
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_stype};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_sbtype};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
        input opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jtype};
    endfunction

    function automatic logic [1:0] mem_width_of(input logic [2:0] f3);
        case (f3)
            3'b000:  return 2'b00;
            3'b001:  return 2'b01;
            default: return 2'b10;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input aluop_t op, input logic [31:0] a,
        input logic [31:0] b);
        logic [31:0] r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_sll: r = a << b[4:0];
            alu_slt: r = {31'b0, $signed(a) < $signed(b)};
            alu_xor: r = a ^ b;
            alu_srl: r = a >> b[4:0];
            alu_sra: r = $signed(a) >>> b[4:0];
            alu_or:  r = a | b;
            alu_and: r = a & b;
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic result_t ref_result(input logic [31:0] instr, input logic [31:0] pc,
        input logic [31:0] a, input logic [31:0] b);
        result_t     r;
        opcode_t     op;
        logic [2:0]  f3;
        logic [4:0]  shamt;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        regw;
        logic        taken;
        op    = opcode_t'(instr[6:0]);
        f3    = instr[14:12];
        shamt = instr[24:20];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        r            = '0;
        r.valid      = 1'b1;
        r.rd         = instr[11:7];
        r.store_data = b;
        r.next_pc    = pc + 32'd4;
        regw         = 1'b0;
        taken        = 1'b0;
        case (op)
            op_rtype, op_rtypew: begin  // w forms give the same 32-bit result
                regw = 1'b1;
                if (f3 != 3'b011) begin
                    r.rd_value = alu_ref(aluop_t'({instr[30], f3}), a, b);
                end
            end
            op_ityper, op_itypeiw: begin
                regw = 1'b1;
                if (f3 == 3'b001) begin
                    r.rd_value = a << shamt;
                end else if (f3 == 3'b101 && instr[30]) begin
                    r.rd_value = $signed(a) >>> shamt;
                end else if (f3 == 3'b101) begin
                    r.rd_value = a >> shamt;
                end else if (f3 == 3'b000) begin
                    r.rd_value = a + imm_i;
                end else if (op == op_ityper && f3 != 3'b011) begin
                    r.rd_value = alu_ref(aluop_t'({1'b0, f3}), a, imm_i);
                end
            end
            op_itypel: begin
                regw        = 1'b1;
                r.mem_read  = 1'b1;
                r.mem_width = mem_width_of(f3);
                r.mem_addr  = a + imm_i;
                r.rd_value  = a + imm_i;  // no data memory here
            end
            op_stype: begin
                r.mem_write = 1'b1;
                r.mem_width = mem_width_of(f3);
                r.mem_addr  = a + imm_s;
            end
            op_utype: begin
                regw       = 1'b1;
                r.rd_value = imm_u;
            end
            op_auipc: begin
                regw       = 1'b1;
                r.rd_value = pc + imm_u;
            end
            op_sbtype: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;  // bltu, bgeu
                endcase
                if (taken) begin
                    r.redirect = 1'b1;
                    r.next_pc  = pc + imm_b;
                end
            end
            op_itypej: begin
                regw       = 1'b1;
                r.rd_value = pc + 32'd4;
                r.redirect = 1'b1;
                r.next_pc  = (a + imm_i) & ~32'd1;
            end
            op_jtype: begin
                regw       = 1'b1;
                r.rd_value = pc + 32'd4;
                r.redirect = 1'b1;
                r.next_pc  = pc + imm_j;
            end
            default: begin
                regw = 1'b0;
            end
        endcase
        r.rd_write = regw && (r.rd != 5'd0);
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_result(input result_t got, input result_t exp);
        check_field("rd_write", 32'(got.rd_write), 32'(exp.rd_write));
        if (exp.rd_write) begin
            check_field("rd", 32'(got.rd), 32'(exp.rd));
            check_field("rd_value", got.rd_value, exp.rd_value);
        end
        check_field("mem_read", 32'(got.mem_read), 32'(exp.mem_read));
        check_field("mem_write", 32'(got.mem_write), 32'(exp.mem_write));
        if (exp.mem_read || exp.mem_write) begin
            check_field("mem_width", 32'(got.mem_width), 32'(exp.mem_width));
            check_field("mem_addr", got.mem_addr, exp.mem_addr);
        end
        if (exp.mem_write) begin
            check_field("store_data", got.store_data, exp.store_data);
        end
        check_field("redirect", 32'(got.redirect), 32'(exp.redirect));
        check_field("next_pc", got.next_pc, exp.next_pc);
    endtask

    task automatic send(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        #2;
        issue.valid   = 1'b1;
        issue.instr   = instr;
        issue.pc      = cur_pc;
        issue.rs1_val = a;
        issue.rs2_val = b;
        exp_q.push_back(ref_result(instr, cur_pc, a, b));
        due_q.push_back(cycle + latency);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            issue.valid = 1'b0;
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d value mismatches, %0d other failures, %0d checks",
                 err_cnt, other_cnt, check_cnt);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("timeout: test did not finish within %0d cycles", max_cycles);
            report_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (result.valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected result at %0t: valid output with no issue pending",
                             $time);
                    other_cnt++;
                end else begin
                    exp_r = exp_q.pop_front();
                    due   = due_q.pop_front();
                    check_field("latency cycle", 32'(cycle), 32'(due));
                    compare_result(result, exp_r);
                end
            end else begin
                check_field("idle controls", 32'({result.rd_write, result.mem_read,
                            result.mem_write, result.redirect}), 32'd0);
                if (due_q.size() != 0 && due_q[0] < cycle) begin
                    $display("missing result at %0t: issue due in cycle %0d never came out",
                             $time, due_q[0]);
                    other_cnt++;
                    exp_r = exp_q.pop_front();
                    due   = due_q.pop_front();
                end
            end
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        int          idx;
        clk    = 1'b0;
        rst_n  = 1'b0;
        issue  = '0;
        rng    = 32'h8061_bee8;
        cur_pc = 32'h0000_1000;
        issue.instr = enc_j(21'h000100, 5'd1);  // jal held with valid low
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(1);
        issue.instr = enc_i(12'h004, 5'd1, 3'd2, 5'd3, op_itypel);  // load held with valid low
        idle(2);  // nothing may come out before the first issue

        send(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5, op_rtype), 32'd7, 32'd5);
        send(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd5, op_rtype), 32'd3, 32'd10);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd5, op_rtype), 32'd1, 32'd33);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd5, op_rtype), 32'hffff_ffff, 32'd1);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd5, op_rtype), 32'hf0f0_1234, 32'h0ff0_ffff);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd5, op_rtype), 32'h8000_0010, 32'd4);
        send(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd5, op_rtype), 32'h8000_0010, 32'd4);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd5, op_rtype), 32'h1200_0034, 32'h0056_7800);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd5, op_rtype), 32'hff00_ff00, 32'h0ff0_0ff0);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd5, op_rtype), 32'd1, 32'd2);  // sltu
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd6, op_rtypew), 32'hffff_ffff, 32'd2);
        send(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd6, op_rtypew), 32'd2, 32'd5);
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, op_rtype), 32'd7, 32'd5);  // rd zero
        idle(1);
        send(enc_i(12'hfff, 5'd1, 3'd0, 5'd8, op_ityper), 32'd10, 32'd0);
        send(enc_i(12'h005, 5'd1, 3'd2, 5'd8, op_ityper), 32'hffff_fffd, 32'd0);
        send(enc_i(12'h8f0, 5'd1, 3'd4, 5'd8, op_ityper), 32'h1234_5678, 32'd0);
        send(enc_i(12'h003, 5'd1, 3'd1, 5'd8, op_ityper), 32'h0000_00ff, 32'd0);
        send(enc_i(12'h008, 5'd1, 3'd5, 5'd8, op_ityper), 32'h8000_0000, 32'd0);
        send(enc_i(12'h408, 5'd1, 3'd5, 5'd8, op_ityper), 32'h8000_0000, 32'd0);
        send(enc_i(12'h7ff, 5'd1, 3'd3, 5'd8, op_ityper), 32'd1, 32'd0);  // sltiu
        send(enc_i(12'h010, 5'd1, 3'd0, 5'd9, op_itypeiw), 32'hffff_fff8, 32'd0);
        send(enc_i(12'h404, 5'd1, 3'd5, 5'd9, op_itypeiw), 32'hf000_0000, 32'd0);
        idle(2);
        send(enc_i(12'hffc, 5'd1, 3'd0, 5'd10, op_itypel), 32'h0000_2000, 32'd0);
        send(enc_i(12'h012, 5'd1, 3'd1, 5'd10, op_itypel), 32'h0000_2000, 32'd0);
        send(enc_i(12'h020, 5'd1, 3'd2, 5'd0, op_itypel), 32'h0000_2000, 32'd0);
        send(enc_s(12'h7ff, 5'd2, 5'd1, 3'd0), 32'h0000_3000, 32'hdead_beef);
        send(enc_s(12'h002, 5'd2, 5'd1, 3'd1), 32'h0000_3000, 32'h0000_1234);
        send(enc_s(12'hff8, 5'd2, 5'd1, 3'd2), 32'h0000_3000, 32'h8765_4321);
        idle(1);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd0), 32'd9, 32'd9);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd0), 32'd1, 32'd9);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd1), 32'd9, 32'd9);
        send(enc_b(13'h1ff8, 5'd2, 5'd1, 3'd1), 32'd20, 32'd9);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd4), 32'hffff_fff0, 32'd3);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd4), 32'd3, 32'hffff_fff0);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd5), 32'd9, 32'd9);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd5), 32'hffff_fff0, 32'd3);
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd6), 32'd1, 32'd9);  // bltu
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd7), 32'd9, 32'd1);  // bgeu
        idle(1);
        send(enc_j(21'h000100, 5'd1), 32'd0, 32'd0);
        send(enc_j(21'h1ffff0, 5'd1), 32'd0, 32'd0);
        send(enc_i(12'h005, 5'd1, 3'd0, 5'd1, op_itypej), 32'h0000_4000, 32'd0);
        send(enc_u(20'habcde, 5'd7, op_utype), 32'd0, 32'd0);
        send(enc_u(20'h00001, 5'd7, op_auipc), 32'd0, 32'd0);
        send(32'h0012_34ff, 32'd1, 32'd2);  // unknown opcodes
        send(32'h0000_000f, 32'd1, 32'd2);

        repeat (n_rand) begin
            next_rand(word);
            next_rand(a);
            next_rand(b);
            if (b[3:0] == 4'd0) begin
                b = a;  // hit the equal compare now and then
            end
            idx = int'(word[6:0]) % 11;
            next_rand(cur_pc);
            cur_pc[1:0] = 2'b00;
            send({word[31:7], legal_ops[idx]}, a, b);
        end
        idle(latency + 2);

        report_counts();
        if (err_cnt == 0 && other_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/riscv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/control_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/exec_core.sv
bench/tb_exec_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the exec_core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exec_core -f flist.f -o sim_exec_core
./obj_dir/sim_exec_core | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
